// File: Bender.yml
package:
  name: pipelined_cpu

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/pipe_pkg.sv
      - src/alu.sv
      - src/regfile.sv
      - src/controller.sv
      - src/forward.sv
      - src/pc.sv
      - src/regwalls.sv
      - src/memctr.sv
      - src/cpu.sv
  - target: test
    files:
      - verif/tb_cpu.sv

// File: build.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/alu.sv
src/regfile.sv
src/controller.sv
src/forward.sv
src/pc.sv
src/regwalls.sv
src/memctr.sv
src/cpu.sv
verif/tb_cpu.sv

// File: src/alu.sv
`default_nettype none

module alu (
	input isa_pkg::alu_fn_e fn,
	input isa_pkg::word_t src_a,
	input isa_pkg::word_t src_b,
	output isa_pkg::word_t result,
	output logic overflow
);
	import isa_pkg::*;

	localparam int MSB = $bits(word_t) - 1;

	logic [4:0] shamt;
	logic [MSB+1:0] wide_sum;
	logic [MSB+1:0] wide_diff;

	assign shamt = src_b[4:0];
	// one extra sign bit so the true result always fits
	assign wide_sum = {src_a[MSB], src_a} + {src_b[MSB], src_b};
	assign wide_diff = {src_a[MSB], src_a} - {src_b[MSB], src_b};

	always_comb begin
		case (fn)
			ADD: result = src_a + src_b;
			SUB: result = src_a - src_b;
			AND: result = src_a & src_b;
			OR: result = src_a | src_b;
			XOR: result = src_a ^ src_b;
			SLT: result = word_t'($signed(src_a) < $signed(src_b));
			SLL: result = src_a << shamt;
			SRL: result = src_a >> shamt;
			default: result = '0;
		endcase
	end

	// signed overflow from the operand and result signs
	always_comb begin
		case (fn)
			ADD: overflow = (src_a[MSB] == src_b[MSB]) && (result[MSB] != src_a[MSB]);
			SUB: overflow = (src_a[MSB] != src_b[MSB]) && (result[MSB] != src_a[MSB]);
			default: overflow = 1'b0;
		endcase
	end

	// top two bits of the wide result differ only on overflow
	always_comb begin
		if (!$isunknown({fn, src_a, src_b})) begin
			assert #0 (overflow == ((fn == ADD && wide_sum[MSB+1] != wide_sum[MSB])
					|| (fn == SUB && wide_diff[MSB+1] != wide_diff[MSB])))
				else $error("alu: overflow flag disagrees with the wide result");
		end
	end

endmodule

`default_nettype wire

// File: src/controller.sv
`default_nettype none

module controller (
	input isa_pkg::word_t instr,
	input isa_pkg::word_t op_a,
	input isa_pkg::word_t op_b,
	output pipe_pkg::ctrl_t ctrl,
	output logic branch_taken
);
	import isa_pkg::*;

	opcode_e opcode;
	reg_addr_t rt;

	assign opcode = opcode_e'(instr[30:25]);
	assign rt = instr[24:20];

	always_comb begin
		ctrl = '0;
		ctrl.dest = rt;
		branch_taken = 1'b0;
		case (opcode)
			ALU: begin
				ctrl.fn = alu_fn_e'(instr[4:0]);
				ctrl.reg_write = 1'b1;
			end
			ADDI: begin
				ctrl.fn = ADD;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			LWI: begin
				ctrl.fn = ADD;
				ctrl.use_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			SWI: begin
				ctrl.fn = ADD;
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			// op_a holds ra, op_b holds rt
			BEQ: begin
				branch_taken = (op_a == op_b);
			end
			BNE: begin
				branch_taken = (op_a != op_b);
			end
			J: begin
				branch_taken = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/cpu.sv
`default_nettype none
`include "cpu_macros.svh"

module cpu (
	input logic clock,
	input logic rst_n,
	input logic do_system,
	output logic alu_overflow,

	output logic IM_read,
	output logic IM_write,
	output logic IM_enable,
	output isa_pkg::word_t IM_address,
	input isa_pkg::word_t IM_out,
	input logic IM_ready,

	output logic DM_read,
	output logic DM_write,
	output logic DM_enable,
	output isa_pkg::word_t DM_address,
	output isa_pkg::word_t DM_in,
	input isa_pkg::word_t DM_out,
	input logic DM_ready,

	output logic IOM_read,
	output logic IOM_write,
	output logic IOM_enable,
	output isa_pkg::word_t IOM_address,
	output isa_pkg::word_t IOM_in,
	input isa_pkg::word_t IOM_out,
	input logic IOM_ready
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic enable_system;
	logic do_hazard;
	logic branch_taken;
	word_t current_pc;
	word_t branch_target;

	if_id_t if_in;
	if_id_t if_id;
	id_ex_t id_in;
	id_ex_t id_ex;
	ex_mem_t ex_in;
	ex_mem_t ex_mem;
	mem_wb_t wb_in;
	mem_wb_t mem_wb;

	opcode_e opcode;
	reg_addr_t rt_addr;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	imm15_t imm15;
	imm14_t imm14;
	imm24_t imm24;
	word_t ra_data;
	word_t rb_data;
	word_t op_a;
	word_t op_b;
	word_t imm_ext;
	word_t offset;
	ctrl_t ctrl;

	word_t alu_result;
	logic alu_ovf;

	logic dm_enable;
	logic dm_read;
	logic dm_write;
	logic iom_enable;
	logic iom_read;
	logic iom_write;
	word_t read_data;
	word_t mem_data;

	// any busy memory freezes the whole pipeline
	assign enable_system = do_system && IM_ready && DM_ready && IOM_ready;

	assign IM_enable = enable_system;
	assign IM_read = 1'b1;
	assign IM_write = 1'b0;
	assign IM_address = current_pc;
	assign if_in = '{instr: IM_out, pc: current_pc};

	assign opcode = opcode_e'(if_id.instr[30:25]);
	assign rt_addr = if_id.instr[24:20];
	assign ra_addr = if_id.instr[19:15];
	// stores and branches read rt through the rb port
	assign rb_addr = (opcode inside {SWI, BEQ, BNE}) ? rt_addr : reg_addr_t'(if_id.instr[14:10]);
	assign imm15 = if_id.instr[14:0];
	assign imm14 = if_id.instr[13:0];
	assign imm24 = if_id.instr[23:0];

	assign imm_ext = {{(`XLEN-15){imm15[14]}}, imm15};
	assign offset = (opcode == J) ? {{(`XLEN-26){imm24[23]}}, imm24, 2'b00}
		: {{(`XLEN-16){imm14[13]}}, imm14, 2'b00};
	assign branch_target = if_id.pc + offset;

	assign id_in = '{ctrl: ctrl, a: op_a, b: ctrl.use_imm ? imm_ext : op_b, store_data: op_b};

	// branch compares and address adds never report overflow
	assign alu_overflow = alu_ovf && id_ex.ctrl.reg_write && !id_ex.ctrl.mem_read;
	assign ex_in = '{ctrl: id_ex.ctrl, result: alu_result, store_data: id_ex.store_data};

	assign DM_enable = dm_enable && enable_system;
	assign DM_read = dm_read && enable_system;
	assign DM_write = dm_write && enable_system;
	assign IOM_enable = iom_enable && enable_system;
	assign IOM_read = iom_read && enable_system;
	assign IOM_write = iom_write && enable_system;

	assign mem_data = ex_mem.ctrl.mem_read ? read_data : ex_mem.result;
	assign wb_in = '{reg_write: ex_mem.ctrl.reg_write, dest: ex_mem.ctrl.dest, data: mem_data};

	pc pc_inst (
		.clock, .rst_n, .enable_system, .do_hazard, .branch_taken,
		.branch_target, .current_pc
	);

	regwalls regwalls_inst (
		.clock, .rst_n, .enable_system, .do_hazard,
		.do_flush(branch_taken),
		.if_in, .id_in, .ex_in, .wb_in,
		.if_id, .id_ex, .ex_mem, .mem_wb
	);

	regfile regfile_inst (
		.clock, .rst_n, .enable_system,
		.ra_addr, .rb_addr, .ra_data, .rb_data,
		.write(mem_wb)
	);

	forward forward_inst (
		.ra_addr, .rb_addr, .ra_data, .rb_data,
		.ex(id_ex),
		.ex_result(alu_result),
		.mem(ex_mem),
		.mem_data,
		.wb(mem_wb),
		.op_a, .op_b, .do_hazard
	);

	controller controller_inst (
		.instr(if_id.instr),
		.op_a, .op_b, .ctrl, .branch_taken
	);

	alu alu_inst (
		.fn(id_ex.ctrl.fn),
		.src_a(id_ex.a),
		.src_b(id_ex.b),
		.result(alu_result),
		.overflow(alu_ovf)
	);

	memctr memctr_inst (
		.access(ex_mem),
		.dm_enable, .dm_read, .dm_write,
		.dm_address(DM_address),
		.dm_in(DM_in),
		.iom_enable, .iom_read, .iom_write,
		.iom_address(IOM_address),
		.iom_in(IOM_in),
		.dm_out(DM_out),
		.iom_out(IOM_out),
		.read_data
	);

endmodule

`default_nettype wire

// File: src/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and address width
`define XLEN 32

`define NREGS 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// set selects the I/O space, clear selects data memory
`define IO_SEL_BIT 31

`endif

// File: src/forward.sv
`default_nettype none

module forward (
	input isa_pkg::reg_addr_t ra_addr,
	input isa_pkg::reg_addr_t rb_addr,
	input isa_pkg::word_t ra_data,
	input isa_pkg::word_t rb_data,
	input pipe_pkg::id_ex_t ex,
	input isa_pkg::word_t ex_result,
	input pipe_pkg::ex_mem_t mem,
	input isa_pkg::word_t mem_data,
	input pipe_pkg::mem_wb_t wb,
	output isa_pkg::word_t op_a,
	output isa_pkg::word_t op_b,
	output logic do_hazard
);
	import isa_pkg::*;

	// youngest writer first
	function automatic word_t bypass(input reg_addr_t addr, input word_t rf_data);
		word_t value;
		value = rf_data;
		if (addr != '0) begin
			if (ex.ctrl.reg_write && ex.ctrl.dest == addr) begin
				value = ex_result;
			end else if (mem.ctrl.reg_write && mem.ctrl.dest == addr) begin
				value = mem_data;
			end else if (wb.reg_write && wb.dest == addr) begin
				value = wb.data;
			end
		end
		return value;
	endfunction

	always_comb begin
		op_a = bypass(ra_addr, ra_data);
		op_b = bypass(rb_addr, rb_data);
	end

	// load data only exists one stage later
	always_comb begin
		do_hazard = ex.ctrl.mem_read && ex.ctrl.dest != '0
			&& (ex.ctrl.dest == ra_addr || ex.ctrl.dest == rb_addr);
	end

endmodule

`default_nettype wire

// File: src/isa_pkg.sv
`default_nettype none
`include "cpu_macros.svh"

package isa_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`NREGS)-1:0] reg_addr_t;

	// addi, lwi, swi byte offset in bits 14:0
	typedef logic [14:0] imm15_t;
	// branch word offset in bits 13:0
	typedef logic [13:0] imm14_t;
	// jump word offset in bits 23:0
	typedef logic [23:0] imm24_t;

	// opcode in bits 30:25
	// rt in bits 24:20, ra in 19:15, rb in 14:10
	typedef enum logic [5:0] {
		NOP  = 6'b000000,
		LWI  = 6'b000010,
		SWI  = 6'b001010,
		ALU  = 6'b100000,
		J    = 6'b100100,
		BEQ  = 6'b100110,
		BNE  = 6'b100111,
		ADDI = 6'b101000
	} opcode_e;

	// function of a register ALU op, bits 4:0
	typedef enum logic [4:0] {
		ADD = 5'b00000,
		SUB = 5'b00001,
		AND = 5'b00010,
		XOR = 5'b00011,
		OR  = 5'b00100,
		SLT = 5'b00110,
		SLL = 5'b01100,
		SRL = 5'b01101
	} alu_fn_e;

endpackage

`default_nettype wire

// File: src/memctr.sv
`default_nettype none
`include "cpu_macros.svh"

module memctr (
	input pipe_pkg::ex_mem_t access,
	output logic dm_enable,
	output logic dm_read,
	output logic dm_write,
	output isa_pkg::word_t dm_address,
	output isa_pkg::word_t dm_in,
	output logic iom_enable,
	output logic iom_read,
	output logic iom_write,
	output isa_pkg::word_t iom_address,
	output isa_pkg::word_t iom_in,
	input isa_pkg::word_t dm_out,
	input isa_pkg::word_t iom_out,
	output isa_pkg::word_t read_data
);

	logic io_sel;

	assign io_sel = access.result[`IO_SEL_BIT];

	assign dm_read = access.ctrl.mem_read && !io_sel;
	assign dm_write = access.ctrl.mem_write && !io_sel;
	assign dm_enable = dm_read || dm_write;
	assign iom_read = access.ctrl.mem_read && io_sel;
	assign iom_write = access.ctrl.mem_write && io_sel;
	assign iom_enable = iom_read || iom_write;

	assign dm_address = access.result;
	assign iom_address = access.result;
	assign dm_in = access.store_data;
	assign iom_in = access.store_data;

	assign read_data = io_sel ? iom_out : dm_out;

	// one space at a time, and never a read and a write together
	always_comb begin
		if (!$isunknown({access.ctrl.mem_read, access.ctrl.mem_write, io_sel})) begin
			assert #0 (!(dm_enable && iom_enable)
					&& !(access.ctrl.mem_read && access.ctrl.mem_write))
				else $error("memctr: conflicting memory strobes");
		end
	end

endmodule

`default_nettype wire

// File: src/pc.sv
`default_nettype none
`include "cpu_macros.svh"

module pc (
	input logic clock,
	input logic rst_n,
	input logic enable_system,
	input logic do_hazard,
	input logic branch_taken,
	input isa_pkg::word_t branch_target,
	output isa_pkg::word_t current_pc
);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			current_pc <= `RESET_PC;
		end else if (enable_system && !do_hazard) begin
			if (branch_taken) begin
				current_pc <= branch_target;
			end else begin
				current_pc <= current_pc + 32'd4;
			end
		end
	end

	// targets come from word offsets added to the decode pc
	assert property (@(posedge clock) disable iff (!rst_n) current_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;
	import isa_pkg::*;

	// all zero is a NOP
	typedef struct packed {
		alu_fn_e fn;
		logic use_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		reg_addr_t dest;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t a;
		word_t b;
		word_t store_data;
	} id_ex_t;

	// result doubles as the load/store address
	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		reg_addr_t dest;
		word_t data;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: src/regfile.sv
`default_nettype none
`include "cpu_macros.svh"

module regfile (
	input logic clock,
	input logic rst_n,
	input logic enable_system,
	input isa_pkg::reg_addr_t ra_addr,
	input isa_pkg::reg_addr_t rb_addr,
	output isa_pkg::word_t ra_data,
	output isa_pkg::word_t rb_data,
	input pipe_pkg::mem_wb_t write
);
	import isa_pkg::*;

	word_t regs [`NREGS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (enable_system && write.reg_write && write.dest != '0) begin
			regs[write.dest] <= write.data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	// r0 reads as zero on both ports
	assert property (@(posedge clock) disable iff (!rst_n)
		(ra_addr != '0 || ra_data == '0) && (rb_addr != '0 || rb_data == '0));

endmodule

`default_nettype wire

// File: src/regwalls.sv
`default_nettype none

module regwalls (
	input logic clock,
	input logic rst_n,
	input logic enable_system,
	input logic do_hazard,
	input logic do_flush,
	input pipe_pkg::if_id_t if_in,
	input pipe_pkg::id_ex_t id_in,
	input pipe_pkg::ex_mem_t ex_in,
	input pipe_pkg::mem_wb_t wb_in,
	output pipe_pkg::if_id_t if_id,
	output pipe_pkg::id_ex_t id_ex,
	output pipe_pkg::ex_mem_t ex_mem,
	output pipe_pkg::mem_wb_t mem_wb
);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			if_id <= '0;
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else if (enable_system) begin
			// stalled decode keeps its instruction
			if (do_hazard) begin
				id_ex <= '0;
			end else begin
				if_id <= do_flush ? '0 : if_in;
				id_ex <= id_in;
			end
			ex_mem <= ex_in;
			mem_wb <= wb_in;
		end
	end

	// a stall beats a flush from a branch waiting on a load
	assert property (@(posedge clock) disable iff (!rst_n)
		enable_system && do_hazard |=> if_id == $past(if_id) && id_ex == '0);

endmodule

`default_nettype wire

// File: verif/tb_cpu.sv
`default_nettype none

module tb_cpu;

	localparam logic [5:0] OP_ALU = 6'b100000;
	localparam logic [5:0] OP_ADDI = 6'b101000;
	localparam logic [5:0] OP_LWI = 6'b000010;
	localparam logic [5:0] OP_SWI = 6'b001010;
	localparam logic [5:0] OP_BEQ = 6'b100110;
	localparam logic [5:0] OP_BNE = 6'b100111;
	localparam logic [5:0] OP_J = 6'b100100;

	localparam logic [4:0] F_ADD = 5'd0;
	localparam logic [4:0] F_SUB = 5'd1;
	localparam logic [4:0] F_AND = 5'd2;
	localparam logic [4:0] F_XOR = 5'd3;
	localparam logic [4:0] F_OR = 5'd4;
	localparam logic [4:0] F_SLT = 5'd6;
	localparam logic [4:0] F_SLL = 5'd12;
	localparam logic [4:0] F_SRL = 5'd13;

	// r30 holds the I/O base, r29 the end marker
	localparam int IO_BASE_REG = 30;
	localparam int MARK_REG = 29;

	logic clock;
	logic rst_n;
	logic do_system;
	logic alu_overflow;
	logic IM_read;
	logic IM_write;
	logic IM_enable;
	logic [31:0] IM_address;
	logic [31:0] IM_out;
	logic IM_ready;
	logic DM_read;
	logic DM_write;
	logic DM_enable;
	logic [31:0] DM_address;
	logic [31:0] DM_in;
	logic [31:0] DM_out;
	logic DM_ready;
	logic IOM_read;
	logic IOM_write;
	logic IOM_enable;
	logic [31:0] IOM_address;
	logic [31:0] IOM_in;
	logic [31:0] IOM_out;
	logic IOM_ready;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] io_reg;
	logic [31:0] io_wr_data;
	logic [31:0] io_wr_addr;
	int io_wr_count;
	int io_rd_count;
	logic [31:0] prog [$];
	logic [31:0] lfsr_state;
	logic drop_on;
	logic [31:0] chain_a;
	logic [31:0] chain_b;
	logic [31:0] chain_c;

	cpu cpu_inst (
		.clock, .rst_n, .do_system, .alu_overflow,
		.IM_read, .IM_write, .IM_enable, .IM_address, .IM_out, .IM_ready,
		.DM_read, .DM_write, .DM_enable, .DM_address, .DM_in, .DM_out, .DM_ready,
		.IOM_read, .IOM_write, .IOM_enable, .IOM_address, .IOM_in, .IOM_out, .IOM_ready
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	// memories read combinationally, word addressed
	assign IM_out = imem[IM_address[7:2]];
	assign DM_out = dmem[DM_address[7:2]];
	assign IOM_out = io_reg;

	task automatic abort_run(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	always @(posedge clock) begin
		if (DM_enable && DM_write) begin
			if (!(do_system && DM_ready)) begin
				abort_run("data memory store while the pipeline was stalled");
			end
			dmem[DM_address[7:2]] <= DM_in;
		end
		if (IOM_enable && IOM_write) begin
			io_reg <= IOM_in;
			io_wr_data <= IOM_in;
			io_wr_addr <= IOM_address;
			io_wr_count <= io_wr_count + 1;
		end
		if (IOM_enable && IOM_read) begin
			io_rd_count <= io_rd_count + 1;
		end
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// random back-pressure for the stall test
	always @(negedge clock) begin
		if (drop_on) begin
			do_system = (lfsr_bits(2) != 0);
			DM_ready = (lfsr_bits(2) != 0);
		end
	end

	function automatic logic [31:0] alu_word(input logic [4:0] fn, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, OP_ALU, rt, ra, rb, 5'b0, fn};
	endfunction

	function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input int imm);
		return {1'b0, op, rt, ra, imm[14:0]};
	endfunction

	function automatic logic [31:0] branch_word(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input int words);
		return {1'b0, op, rt, ra, 1'b0, words[13:0]};
	endfunction

	function automatic logic [31:0] jump_word(input int words);
		return {1'b0, OP_J, 1'b0, words[23:0]};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// r30 = 1 << 31
	task automatic add_preamble();
		prog.delete();
		emit(imm_word(OP_ADDI, 1, 0, 1));
		emit(imm_word(OP_ADDI, 2, 0, 31));
		emit(alu_word(F_SLL, IO_BASE_REG, 1, 2));
	endtask

	// marker to I/O, then spin on a jump to itself
	task automatic add_finish(input int marker);
		emit(imm_word(OP_ADDI, MARK_REG, 0, marker));
		emit(imm_word(OP_SWI, MARK_REG, IO_BASE_REG, 0));
		emit(jump_word(0));
	endtask

	task automatic load_program();
		@(negedge clock);
		rst_n = 1'b0;
		drop_on = 1'b0;
		do_system = 1'b1;
		DM_ready = 1'b1;
		if (prog.size() > 64) begin
			abort_run("program does not fit in instruction memory");
		end
		for (int i = 0; i < 64; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
			dmem[i] = '0;
		end
		io_reg = '0;
		io_wr_count = 0;
		io_rd_count = 0;
	endtask

	task automatic release_reset();
		repeat (8) @(negedge clock);
		check_value("DM_enable", {31'b0, DM_enable}, 32'd0);
		check_value("DM_read", {31'b0, DM_read}, 32'd0);
		check_value("DM_write", {31'b0, DM_write}, 32'd0);
		check_value("IOM_enable", {31'b0, IOM_enable}, 32'd0);
		check_value("IOM_read", {31'b0, IOM_read}, 32'd0);
		check_value("IOM_write", {31'b0, IOM_write}, 32'd0);
		check_value("IM_write", {31'b0, IM_write}, 32'd0);
		check_value("IM_read", {31'b0, IM_read}, 32'd1);
		check_value("IM_enable", {31'b0, IM_enable}, 32'd1);
		check_value("alu_overflow", {31'b0, alu_overflow}, 32'd0);
		check_value("IM_address", IM_address, 32'd0);
		rst_n = 1'b1;
	endtask

	task automatic run_until_io_write(input int limit, input logic [31:0] marker);
		int cycles;
		cycles = 0;
		while (io_wr_count == 0 && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (io_wr_count == 0) begin
			abort_run("no I/O write arrived to end the program");
		end
		check_value("IOM_address", io_wr_addr, 32'h8000_0000);
		check_value("IOM_in", io_wr_data, marker);
	endtask

	task automatic wait_for_overflow(input int limit);
		int cycles;
		cycles = 0;
		while (!alu_overflow && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (!alu_overflow) begin
			abort_run("alu_overflow never went high");
		end
	endtask

	task automatic alu_chain_test(input logic with_drops);
		logic [31:0] expected [13];
		logic [4:0] sh;
		sh = chain_c[4:0];
		expected[4] = chain_a + chain_b;
		expected[5] = expected[4] - chain_a;
		expected[6] = expected[5] & expected[4];
		expected[7] = expected[6] | chain_c;
		expected[8] = expected[7] ^ expected[5];
		expected[9] = ($signed(expected[8]) < $signed(expected[4])) ? 32'd1 : 32'd0;
		expected[10] = expected[8] << sh;
		expected[11] = expected[10] >> sh;
		expected[12] = ($signed(chain_a) < $signed(chain_b)) ? 32'd1 : 32'd0;
		add_preamble();
		emit(imm_word(OP_LWI, 1, 0, 0));
		emit(imm_word(OP_LWI, 2, 0, 4));
		emit(imm_word(OP_LWI, 3, 0, 8));
		emit(alu_word(F_ADD, 4, 1, 2));
		emit(alu_word(F_SUB, 5, 4, 1));
		emit(alu_word(F_AND, 6, 5, 4));
		emit(alu_word(F_OR, 7, 6, 3));
		emit(alu_word(F_XOR, 8, 7, 5));
		emit(alu_word(F_SLT, 9, 8, 4));
		emit(alu_word(F_SLL, 10, 8, 3));
		emit(alu_word(F_SRL, 11, 10, 3));
		emit(alu_word(F_SLT, 12, 1, 2));
		for (int k = 4; k <= 12; k++) begin
			emit(imm_word(OP_SWI, k, 0, k * 4));
		end
		add_finish(16'h0a11);
		load_program();
		dmem[0] = chain_a;
		dmem[1] = chain_b;
		dmem[2] = chain_c;
		release_reset();
		drop_on = with_drops;
		run_until_io_write(with_drops ? 1000 : 200, 32'h0000_0a11);
		for (int k = 4; k <= 12; k++) begin
			check_value($sformatf("dmem[%0d]", k), dmem[k], expected[k]);
		end
	endtask

	task automatic load_use_test();
		logic [31:0] x;
		logic [31:0] y;
		x = lfsr_bits(32);
		y = lfsr_bits(32);
		add_preamble();
		emit(imm_word(OP_LWI, 1, 0, 0));
		emit(imm_word(OP_LWI, 2, 0, 4));
		emit(alu_word(F_ADD, 3, 1, 2));
		emit(imm_word(OP_SWI, 3, 0, 8));
		emit(imm_word(OP_LWI, 4, 0, 8));
		emit(imm_word(OP_ADDI, 5, 4, 5));
		emit(imm_word(OP_SWI, 5, 0, 12));
		// store data that comes straight from a load
		emit(imm_word(OP_LWI, 6, 0, 0));
		emit(imm_word(OP_SWI, 6, 0, 16));
		add_finish(16'h0b22);
		load_program();
		dmem[0] = x;
		dmem[1] = y;
		release_reset();
		run_until_io_write(200, 32'h0000_0b22);
		check_value("dmem[2]", dmem[2], x + y);
		check_value("dmem[3]", dmem[3], x + y + 32'd5);
		check_value("dmem[4]", dmem[4], x);
	endtask

	task automatic branch_test();
		add_preamble();
		emit(imm_word(OP_ADDI, 20, 0, 0));
		emit(imm_word(OP_ADDI, 21, 0, 0));
		emit(imm_word(OP_ADDI, 3, 0, 7));
		emit(imm_word(OP_ADDI, 1, 0, 5));
		emit(imm_word(OP_ADDI, 2, 0, 5));
		// taken beq, the slot after it must not run
		emit(branch_word(OP_BEQ, 2, 1, 2));
		emit(imm_word(OP_ADDI, 20, 20, 1));
		emit(branch_word(OP_BNE, 3, 1, 2));
		emit(imm_word(OP_ADDI, 20, 20, 2));
		// not taken, both fall through
		emit(branch_word(OP_BEQ, 3, 1, 2));
		emit(imm_word(OP_ADDI, 21, 21, 1));
		emit(branch_word(OP_BNE, 2, 1, 2));
		emit(imm_word(OP_ADDI, 21, 21, 2));
		emit(jump_word(2));
		emit(imm_word(OP_ADDI, 20, 20, 4));
		emit(imm_word(OP_SWI, 20, 0, 0));
		emit(imm_word(OP_SWI, 21, 0, 4));
		add_finish(16'h0c33);
		load_program();
		release_reset();
		run_until_io_write(200, 32'h0000_0c33);
		check_value("flag r20", dmem[0], 32'd0);
		check_value("count r21", dmem[1], 32'd3);
	endtask

	task automatic io_test();
		logic [31:0] io_value;
		logic [31:0] sentinel;
		io_value = lfsr_bits(32);
		sentinel = lfsr_bits(32);
		add_preamble();
		emit(imm_word(OP_LWI, 5, IO_BASE_REG, 0));
		emit(imm_word(OP_SWI, 5, 0, 8));
		// the closing I/O store doubles as the routed store
		add_finish(16'h1234);
		load_program();
		dmem[0] = sentinel;
		io_reg = io_value;
		release_reset();
		run_until_io_write(200, 32'h0000_1234);
		check_value("IOM_read count", io_rd_count, 32'd1);
		check_value("dmem[0]", dmem[0], sentinel);
		check_value("dmem[2]", dmem[2], io_value);
	endtask

	task automatic overflow_test();
		logic [31:0] max_pos;
		max_pos = 32'h7fff_ffff;
		add_preamble();
		emit(imm_word(OP_ADDI, 1, 0, -1));
		emit(imm_word(OP_ADDI, 2, 0, 1));
		emit(alu_word(F_SRL, 3, 1, 2));
		emit(alu_word(F_ADD, 4, 3, 2));
		emit(imm_word(OP_SWI, 4, 0, 0));
		add_finish(16'h0d44);
		load_program();
		release_reset();
		wait_for_overflow(50);
		run_until_io_write(200, 32'h0000_0d44);
		check_value("dmem[0]", dmem[0], max_pos + 32'd1);
	endtask

	initial begin
		rst_n = 1'b0;
		do_system = 1'b1;
		IM_ready = 1'b1;
		DM_ready = 1'b1;
		IOM_ready = 1'b1;
		drop_on = 1'b0;
		io_reg = '0;
		io_wr_data = '0;
		io_wr_addr = '0;
		io_wr_count = 0;
		io_rd_count = 0;
		lfsr_state = 32'h9069;
		chain_a = lfsr_bits(32);
		chain_b = lfsr_bits(32);
		chain_c = lfsr_bits(32);
		alu_chain_test(1'b0);
		load_use_test();
		branch_test();
		io_test();
		overflow_test();
		// same chain and operands under back-pressure
		alu_chain_test(1'b1);
		drop_on = 1'b0;
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
